// File: tb.f
logic/raster_pkg.sv
logic/axi_tri_writer.sv
logic/tri_fifo.sv
logic/draw_controller.sv
logic/frame_buffer.sv
logic/pixel_scan.sv
logic/tri_raster_top.sv
tests/tb_assertions.sv
tests/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator from tb.f, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim \
  > build.log 2>&1 &&
  ./obj_dir/tb_sim > sim.log 2>&1 ||
  echo "*** FAILED ***" >> sim.log
cat build.log sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

// File: tests/tb_top.sv
// testbench top for the triangle raster peripheral; writes triangle records, scans the image back
`timescale 1ns/100ps
`default_nettype none

module tb_top;

  // worst case is three full clear sweeps plus the scans and fills
  localparam int timeout_cycles = 3 * raster_pkg::fb_depth + 20000;
  localparam int box_max = 16;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef struct packed {
    raster_pkg::coord_x_t x1;
    raster_pkg::coord_y_t y1;
    raster_pkg::coord_x_t x2;
    raster_pkg::coord_y_t y2;
    raster_pkg::coord_x_t x3;
    raster_pkg::coord_y_t y3;
    raster_pkg::pixel_t   color;
  } tri_t;

  typedef struct packed {
    int x0;
    int x1;
    int y0;
    int y1;
  } box_t;

  logic S_AXI_ACLK = 1'b0;
  logic S_AXI_ARESETN;
  logic vsync;
  logic [9:0] drawX;
  logic [9:0] drawY;
  logic [raster_pkg::addr_width-1:0] S_AXI_AWADDR;
  logic S_AXI_AWVALID;
  logic S_AXI_AWREADY;
  raster_pkg::word_t S_AXI_WDATA;
  logic S_AXI_WVALID;
  logic S_AXI_WREADY;
  logic [1:0] S_AXI_BRESP;
  logic S_AXI_BVALID;
  logic S_AXI_BREADY;
  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;

  // image model, painted in push order
  raster_pkg::pixel_t model [raster_pkg::fb_depth];
  box_t drawn [$];
  int unsigned rng_state = 32'd22;
  int unsigned cycle_count = 0;
  logic scan_on;
  // expected colour lines up with the one-cycle read latency
  logic chk_q = 1'b0;
  rgb_t exp_q;

  tri_raster_top u_tri_raster_top (.*);

  bind tri_raster_top tb_assertions u_tb_assertions (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY)
  );

  always #4 S_AXI_ACLK = ~S_AXI_ACLK;

  ////////////////////
  // helpers
  ////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [3:0] exp, input logic [3:0] got);
    $display("FAILED %s expected %h got %h", name, exp, got);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // rgb332 widened, each field padded with zeros below
  function automatic rgb_t widen(input raster_pkg::pixel_t p);
    rgb_t c;
    c.r = {p[7:5], 1'b0};
    c.g = {p[4:2], 1'b0};
    c.b = {p[1:0], 2'b00};
    return c;
  endfunction

  // scan position at half resolution
  function automatic int scan_index(input logic [9:0] dx, input logic [9:0] dy);
    return int'(dy >> 1) * raster_pkg::screen_w + int'(dx >> 1);
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) % n;
  endfunction

  // vertices spread over a box_max square from the base corner
  function automatic tri_t random_tri(input int bx, input int by);
    tri_t t;
    t.x1 = raster_pkg::coord_x_t'(bx + int'(rand_below(box_max)));
    t.y1 = raster_pkg::coord_y_t'(by + int'(rand_below(box_max)));
    t.x2 = raster_pkg::coord_x_t'(bx + int'(rand_below(box_max)));
    t.y2 = raster_pkg::coord_y_t'(by + int'(rand_below(box_max)));
    t.x3 = raster_pkg::coord_x_t'(bx + int'(rand_below(box_max)));
    t.y3 = raster_pkg::coord_y_t'(by + int'(rand_below(box_max)));
    // never black, so a fill is always visible
    t.color = raster_pkg::pixel_t'(1 + rand_below(255));
    return t;
  endfunction

  // six bus words, reserved depth and area fields random
  function automatic logic [5:0][31:0] make_record(input tri_t t);
    logic [5:0][31:0] w;
    w[0] = {8'h00, t.y1, 7'h00, t.x1};
    w[1] = {7'h00, t.x2, 16'(rand_below(65536))};
    w[2] = {16'(rand_below(65536)), 8'h00, t.y2};
    w[3] = {8'h00, t.y3, 7'h00, t.x3};
    w[4] = {8'h00, t.color, 16'(rand_below(65536))};
    w[5] = {16'(rand_below(65536)), 16'(rand_below(65536))};
    return w;
  endfunction

  function automatic int min3(input int a, input int b, input int c);
    int m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic int max3(input int a, input int b, input int c);
    int m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  function automatic box_t tri_box(input tri_t t);
    box_t b;
    b.x0 = min3(int'(t.x1), int'(t.x2), int'(t.x3));
    b.x1 = max3(int'(t.x1), int'(t.x2), int'(t.x3));
    b.y0 = min3(int'(t.y1), int'(t.y2), int'(t.y3));
    b.y1 = max3(int'(t.y1), int'(t.y2), int'(t.y3));
    return b;
  endfunction

  function automatic int box_area(input tri_t t);
    box_t b;
    b = tri_box(t);
    return (b.x1 - b.x0 + 1) * (b.y1 - b.y0 + 1);
  endfunction

  task automatic paint_model(input tri_t t);
    box_t b;
    b = tri_box(t);
    for (int y = b.y0; y <= b.y1; y++) begin
      for (int x = b.x0; x <= b.x1; x++) begin
        model[y * raster_pkg::screen_w + x] = t.color;
      end
    end
    drawn.push_back(b);
  endtask

  task automatic clear_model();
    for (int i = 0; i < raster_pkg::fb_depth; i++) begin
      model[i] = raster_pkg::clear_color;
    end
  endtask

  ////////////////////
  // bus and scan drivers
  ////////////////////
  // one write, response held off for hold cycles
  // while it is held a write to the ignored index 6 waits on the bus
  task automatic axi_write(input int idx, input raster_pkg::word_t data, input int hold);
    S_AXI_AWADDR <= 5'(idx * 4);
    S_AXI_WDATA <= data;
    S_AXI_AWVALID <= 1'b1;
    S_AXI_WVALID <= 1'b1;
    @(posedge S_AXI_ACLK);
    while (!S_AXI_AWREADY) @(posedge S_AXI_ACLK);
    if (hold > 0) begin
      S_AXI_AWADDR <= 5'd24;
    end else begin
      S_AXI_AWVALID <= 1'b0;
      S_AXI_WVALID <= 1'b0;
    end
    repeat (hold) @(posedge S_AXI_ACLK);
    S_AXI_BREADY <= 1'b1;
    @(posedge S_AXI_ACLK);
    while (!S_AXI_BVALID) @(posedge S_AXI_ACLK);
    S_AXI_BREADY <= 1'b0;
    // waiting write goes through once the response is taken
    if (hold > 0) begin
      @(posedge S_AXI_ACLK);
      while (!S_AXI_AWREADY) @(posedge S_AXI_ACLK);
      S_AXI_AWVALID <= 1'b0;
      S_AXI_WVALID <= 1'b0;
      S_AXI_BREADY <= 1'b1;
      @(posedge S_AXI_ACLK);
      while (!S_AXI_BVALID) @(posedge S_AXI_ACLK);
      S_AXI_BREADY <= 1'b0;
    end
  endtask

  task automatic send_words(input logic [5:0][31:0] w, input int first, input int last,
                            input int hold);
    for (int i = first; i <= last; i++) begin
      axi_write(i, w[i], hold);
    end
  endtask

  // odd scan offsets exercise the half-resolution mapping
  task automatic scan_area(input int x0, input int x1, input int y0, input int y1, input int ystep);
    for (int y = y0; y <= y1; y += ystep) begin
      for (int x = x0; x <= x1; x++) begin
        drawX <= 10'(2 * x + (y & 1));
        drawY <= 10'(2 * y + (x & 1));
        scan_on <= 1'b1;
        @(posedge S_AXI_ACLK);
      end
    end
    scan_on <= 1'b0;
    repeat (2) @(posedge S_AXI_ACLK);
  endtask

  // box plus a two-pixel border, clipped to the screen
  task automatic scan_around(input box_t b);
    scan_area((b.x0 >= 2) ? b.x0 - 2 : 0,
              (b.x1 + 2 < raster_pkg::screen_w) ? b.x1 + 2 : raster_pkg::screen_w - 1,
              (b.y0 >= 2) ? b.y0 - 2 : 0,
              (b.y1 + 2 < raster_pkg::screen_h) ? b.y1 + 2 : raster_pkg::screen_h - 1, 1);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge S_AXI_ACLK);
  endtask

  ////////////////////
  // pixel checks
  ////////////////////
  always @(posedge S_AXI_ACLK) begin
    exp_q <= widen(model[scan_index(drawX, drawY)]);
    chk_q <= scan_on;
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      fail_run("timeout, the test did not finish within the cycle limit");
    end
  end

  a_red: assert property (@(posedge S_AXI_ACLK) chk_q |-> red == exp_q.r)
    else report_mismatch("red", $sampled(exp_q.r), $sampled(red));
  a_green: assert property (@(posedge S_AXI_ACLK) chk_q |-> green == exp_q.g)
    else report_mismatch("green", $sampled(exp_q.g), $sampled(green));
  a_blue: assert property (@(posedge S_AXI_ACLK) chk_q |-> blue == exp_q.b)
    else report_mismatch("blue", $sampled(exp_q.b), $sampled(blue));

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    tri_t t;
    logic [5:0][31:0] w;
    int area;
    int bx;
    int by;
    clear_model();
    S_AXI_ARESETN <= 1'b0;
    vsync <= 1'b0;
    drawX <= '0;
    drawY <= '0;
    scan_on <= 1'b0;
    S_AXI_AWADDR <= '0;
    S_AXI_AWVALID <= 1'b0;
    S_AXI_WDATA <= '0;
    S_AXI_WVALID <= 1'b0;
    S_AXI_BREADY <= 1'b0;
    repeat (8) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;

    // first clear sweep, then a sparse scan of the black screen
    wait_cycles(raster_pkg::fb_depth + 16);
    scan_area(0, raster_pkg::screen_w - 1, 0, raster_pkg::screen_h - 1, 8);

    // one record, response held back to stress bvalid
    t = random_tri(int'(rand_below(304)), int'(rand_below(224)));
    send_words(make_record(t), 0, 5, 3);
    paint_model(t);
    wait_cycles(box_area(t) + 24);
    scan_around(tri_box(t));

    // five overlapping records back to back
    bx = int'(rand_below(296));
    by = int'(rand_below(216));
    area = 0;
    for (int n = 0; n < 5; n++) begin
      t = random_tri(bx + int'(rand_below(8)), by + int'(rand_below(8)));
      send_words(make_record(t), 0, 5, 0);
      paint_model(t);
      area += box_area(t) + 4;
    end
    wait_cycles(area + 32);
    scan_around('{bx, bx + 7 + box_max - 1, by, by + 7 + box_max - 1});

    // words 0 to 4 only, nothing drawn until word 5
    t = random_tri(int'(rand_below(304)), int'(rand_below(224)));
    w = make_record(t);
    send_words(w, 0, 4, 1);
    wait_cycles(box_max * box_max + 24);
    scan_around(tri_box(t));
    send_words(w, 5, 5, 0);
    paint_model(t);
    wait_cycles(box_area(t) + 24);
    scan_around(tri_box(t));

    // vsync restarts the clear from wait_tri
    vsync <= 1'b1;
    wait_cycles(4);
    vsync <= 1'b0;
    wait_cycles(raster_pkg::fb_depth + 16);
    clear_model();
    foreach (drawn[i]) begin
      scan_around(drawn[i]);
    end
    scan_area(0, raster_pkg::screen_w - 1, 4, raster_pkg::screen_h - 1, 8);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_assertions.sv
// AXI write channel protocol and reset checks, bound onto the raster top level by the testbench
`timescale 1ns/100ps
`default_nettype none

module tb_assertions (
  input wire       S_AXI_ACLK,
  input wire       S_AXI_ARESETN,
  input wire       S_AXI_AWVALID,
  input wire       S_AXI_AWREADY,
  input wire       S_AXI_WVALID,
  input wire       S_AXI_WREADY,
  input wire [1:0] S_AXI_BRESP,
  input wire       S_AXI_BVALID,
  input wire       S_AXI_BREADY
);

  ////////////////////
  // reset
  ////////////////////
  // outputs low on the edge after reset is seen
  a_reset_values: assert property (@(posedge S_AXI_ACLK)
    !S_AXI_ARESETN |=> !S_AXI_AWREADY && !S_AXI_WREADY && !S_AXI_BVALID && S_AXI_BRESP == 2'b00)
    else $error("write channel outputs not cleared by reset");

  ////////////////////
  // ready pulse
  ////////////////////
  a_ready_equal: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY == S_AXI_WREADY)
    else $error("awready and wready differ");

  a_ready_one_cycle: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY |=> !S_AXI_AWREADY)
    else $error("ready pulse longer than one cycle");

  // ready only answers both valids, so it stays low before the first write
  a_ready_needs_valid: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY |-> $past(S_AXI_AWVALID && S_AXI_WVALID))
    else $error("ready raised without both valids");

  ////////////////////
  // write response
  ////////////////////
  a_bvalid_after_ready: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_AWREADY |=> S_AXI_BVALID && S_AXI_BRESP == 2'b00)
    else $error("no okay response on the edge after the ready pulse");

  // response only follows a ready pulse, so bvalid is low before the first write
  a_bvalid_needs_ready: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(S_AXI_BVALID) |-> $past(S_AXI_AWREADY))
    else $error("bvalid raised without a ready pulse");

  a_bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
    else $error("bvalid dropped before bready");

  a_bresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID |-> S_AXI_BRESP == 2'b00)
    else $error("bresp not okay");

  // back pressure, no new write while the response is pending
  a_no_ready_in_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID |-> !S_AXI_AWREADY && !S_AXI_WREADY)
    else $error("write accepted while a response is pending");

endmodule

`default_nettype wire

// File: logic/tri_raster_top.sv
// top level of the triangle raster peripheral, connects bus writer, queue, draw FSM and scan-out
`timescale 1ns/100ps
`default_nettype none

module tri_raster_top (
  input  wire                                S_AXI_ACLK,
  input  wire                                S_AXI_ARESETN,
  input  wire                                vsync,
  input  wire  [9:0]                         drawX,
  input  wire  [9:0]                         drawY,
  input  wire  [raster_pkg::addr_width-1:0]  S_AXI_AWADDR,
  input  wire                                S_AXI_AWVALID,
  output logic                               S_AXI_AWREADY,
  input  wire  raster_pkg::word_t            S_AXI_WDATA,
  input  wire                                S_AXI_WVALID,
  output logic                               S_AXI_WREADY,
  output logic [1:0]                         S_AXI_BRESP,
  output logic                               S_AXI_BVALID,
  input  wire                                S_AXI_BREADY,
  output logic [3:0]                         red,
  output logic [3:0]                         green,
  output logic [3:0]                         blue
);

  // writer to queue
  logic push;
  logic fifo_full;
  raster_pkg::tri_word_u push_rec;
  // queue to draw FSM
  logic pop;
  logic fifo_empty;
  raster_pkg::tri_word_u head_rec;
  // frame buffer ports
  raster_pkg::fb_wr_t fb_wr;
  raster_pkg::fb_addr_t rd_addr;
  raster_pkg::pixel_t rd_data;

  axi_tri_writer u_axi_tri_writer (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .fifo_full     (fifo_full),
    .push          (push),
    .rec           (push_rec)
  );

  tri_fifo u_tri_fifo (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .push          (push),
    .rec_in        (push_rec),
    .pop           (pop),
    .rec_out       (head_rec),
    .full          (fifo_full),
    .empty         (fifo_empty)
  );

  draw_controller u_draw_controller (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .vsync         (vsync),
    .rec           (head_rec),
    .empty         (fifo_empty),
    .pop           (pop),
    .fb_wr         (fb_wr)
  );

  frame_buffer u_frame_buffer (
    .S_AXI_ACLK (S_AXI_ACLK),
    .fb_wr      (fb_wr),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

  pixel_scan u_pixel_scan (
    .drawX   (drawX),
    .drawY   (drawY),
    .rd_data (rd_data),
    .rd_addr (rd_addr),
    .red     (red),
    .green   (green),
    .blue    (blue)
  );

endmodule

`default_nettype wire

// File: logic/pixel_scan.sv
// maps the 640x480 scan position onto the frame buffer and widens rgb332 to 4-bit channels
`timescale 1ns/100ps
`default_nettype none

module pixel_scan (
  input  wire [9:0]                drawX,
  input  wire [9:0]                drawY,
  input  wire raster_pkg::pixel_t  rd_data,
  output raster_pkg::fb_addr_t     rd_addr,
  output logic [3:0]               red,
  output logic [3:0]               green,
  output logic [3:0]               blue
);

  raster_pkg::coord_x_t buf_x;
  raster_pkg::coord_y_t buf_y;

  // half resolution, each buffer pixel covers 2x2 scan pixels
  assign buf_x = drawX[9:1];
  assign buf_y = drawY[8:1];
  assign rd_addr = raster_pkg::pixel_addr(buf_x, buf_y);

  // pad each field with zeros at the bottom
  assign red = {rd_data[7:5], 1'b0};
  assign green = {rd_data[4:2], 1'b0};
  assign blue = {rd_data[1:0], 2'b00};

endmodule

`default_nettype wire

// File: logic/frame_buffer.sv
// 320x240 rgb332 pixel memory, written by the draw controller and read by the scan-out path
`timescale 1ns/100ps
`default_nettype none

module frame_buffer (
  input  wire                        S_AXI_ACLK,
  input  wire raster_pkg::fb_wr_t    fb_wr,
  input  wire raster_pkg::fb_addr_t  rd_addr,
  output raster_pkg::pixel_t         rd_data
);

  // one byte per pixel
  raster_pkg::pixel_t mem [raster_pkg::fb_depth];

  ////////////////////
  // draw side write port
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (fb_wr.en) begin
      mem[fb_wr.addr] <= fb_wr.data;
    end
  end

  ////////////////////
  // scan side read port
  ////////////////////
  // registered read, data one cycle after the address
  always_ff @(posedge S_AXI_ACLK) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: logic/draw_controller.sv
// draw FSM: clears the frame buffer on vsync, pops triangles and fills their bounding boxes
`timescale 1ns/100ps
`default_nettype none

module draw_controller (
  input  wire                         S_AXI_ACLK,
  input  wire                         S_AXI_ARESETN,
  input  wire                         vsync,
  input  wire raster_pkg::tri_word_u  rec,
  input  wire                         empty,
  output logic                        pop,
  output raster_pkg::fb_wr_t          fb_wr
);

  logic vsync_s1;
  logic vsync_s2;
  logic vsync_prev;
  logic vsync_rise;
  raster_pkg::draw_state_e state;
  raster_pkg::fb_addr_t clear_addr;
  raster_pkg::tri_fields_t tri_q;
  // first fill cycle, box being loaded
  logic setup;
  logic box_end;
  raster_pkg::coord_x_t bx_min;
  raster_pkg::coord_x_t bx_max;
  raster_pkg::coord_y_t by_min;
  raster_pkg::coord_y_t by_max;
  raster_pkg::coord_x_t x_lo;
  raster_pkg::coord_x_t x_hi;
  raster_pkg::coord_y_t y_hi;
  raster_pkg::coord_x_t cur_x;
  raster_pkg::coord_y_t cur_y;

  ////////////////////
  // vsync synchroniser and rising edge
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      vsync_s1 <= 1'b0;
      vsync_s2 <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      vsync_s1 <= vsync;
      vsync_s2 <= vsync_s1;
      vsync_prev <= vsync_s2;
    end
  end

  assign vsync_rise = vsync_s2 && !vsync_prev;

  // pop the head while idle, unless a clear takes priority
  assign pop = (state == raster_pkg::wait_tri) && !empty && !vsync_rise;

  // bounding box of the latched vertices
  always_comb begin
    bx_min = tri_q.v1x;
    bx_max = tri_q.v1x;
    by_min = tri_q.v1y;
    by_max = tri_q.v1y;
    if (tri_q.v2x < bx_min) bx_min = tri_q.v2x;
    if (tri_q.v3x < bx_min) bx_min = tri_q.v3x;
    if (tri_q.v2x > bx_max) bx_max = tri_q.v2x;
    if (tri_q.v3x > bx_max) bx_max = tri_q.v3x;
    if (tri_q.v2y < by_min) by_min = tri_q.v2y;
    if (tri_q.v3y < by_min) by_min = tri_q.v3y;
    if (tri_q.v2y > by_max) by_max = tri_q.v2y;
    if (tri_q.v3y > by_max) by_max = tri_q.v3y;
  end

  // last pixel of the box
  assign box_end = (cur_x == x_hi) && (cur_y == y_hi);

  ////////////////////
  // state register and clear counter
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state <= raster_pkg::clear;
      clear_addr <= '0;
      setup <= 1'b0;
    end else begin
      case (state)
        raster_pkg::clear: begin
          clear_addr <= clear_addr + 1'b1;
          if (clear_addr == raster_pkg::fb_addr_t'(raster_pkg::fb_depth - 1)) begin
            clear_addr <= '0;
            state <= raster_pkg::wait_tri;
          end
        end
        raster_pkg::wait_tri: begin
          // a vsync edge during a fill is not seen here
          if (vsync_rise) begin
            state <= raster_pkg::clear;
          end else if (!empty) begin
            state <= raster_pkg::fill;
            setup <= 1'b1;
          end
        end
        raster_pkg::fill: begin
          if (setup) begin
            setup <= 1'b0;
          end else if (box_end) begin
            state <= raster_pkg::wait_tri;
          end
        end
        default: state <= raster_pkg::clear;
      endcase
    end
  end

  // record latch and box walk, row by row
  always_ff @(posedge S_AXI_ACLK) begin
    if (pop) begin
      tri_q <= rec.fields;
    end
    if (state == raster_pkg::fill) begin
      if (setup) begin
        x_lo <= bx_min;
        x_hi <= bx_max;
        y_hi <= by_max;
        cur_x <= bx_min;
        cur_y <= by_min;
      end else if (cur_x == x_hi) begin
        cur_x <= x_lo;
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  // write port, one pixel per cycle
  always_comb begin
    fb_wr.en = 1'b0;
    fb_wr.addr = raster_pkg::pixel_addr(cur_x, cur_y);
    fb_wr.data = tri_q.color;
    if (state == raster_pkg::clear) begin
      fb_wr.en = 1'b1;
      fb_wr.addr = clear_addr;
      fb_wr.data = raster_pkg::clear_color;
    end else if (state == raster_pkg::fill && !setup) begin
      fb_wr.en = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/tri_fifo.sv
// synchronous queue of triangle records between the bus writer and the draw controller
`timescale 1ns/100ps
`default_nettype none

module tri_fifo (
  input  wire                         S_AXI_ACLK,
  input  wire                         S_AXI_ARESETN,
  input  wire                         push,
  input  wire raster_pkg::tri_word_u  rec_in,
  input  wire                         pop,
  output raster_pkg::tri_word_u       rec_out,
  output logic                        full,
  output logic                        empty
);

  raster_pkg::tri_word_u mem [raster_pkg::fifo_depth];
  logic [$clog2(raster_pkg::fifo_depth)-1:0] wr_ptr;
  logic [$clog2(raster_pkg::fifo_depth)-1:0] rd_ptr;
  // one extra bit so a full queue is distinct from an empty one
  logic [$clog2(raster_pkg::fifo_depth):0] count;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop = pop && !empty;
  // count top bit set means all entries used
  assign full = count[$clog2(raster_pkg::fifo_depth)];
  assign empty = (count == '0);
  // head always visible
  assign rec_out = mem[rd_ptr];

  always_ff @(posedge S_AXI_ACLK) begin
    if (do_push) begin
      mem[wr_ptr] <= rec_in;
    end
  end

  // pointers wrap on the power-of-two depth
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/axi_tri_writer.sv
// axi4-lite write slave that gathers six words and pushes a complete triangle record to the queue
`timescale 1ns/100ps
`default_nettype none

module axi_tri_writer (
  input  wire                                 S_AXI_ACLK,
  input  wire                                 S_AXI_ARESETN,
  input  wire  [raster_pkg::addr_width-1:0]   S_AXI_AWADDR,
  input  wire                                 S_AXI_AWVALID,
  output logic                                S_AXI_AWREADY,
  input  wire  raster_pkg::word_t             S_AXI_WDATA,
  input  wire                                 S_AXI_WVALID,
  output logic                                S_AXI_WREADY,
  output logic [1:0]                          S_AXI_BRESP,
  output logic                                S_AXI_BVALID,
  input  wire                                 S_AXI_BREADY,
  input  wire                                 fifo_full,
  output logic                                push,
  output raster_pkg::tri_word_u               rec
);

  // high while no transaction is open
  logic aw_en;
  logic accept;
  logic wr_fire;
  logic [raster_pkg::addr_width-1:0] awaddr_q;
  logic [2:0] word_idx;
  raster_pkg::tri_word_u word_regs;
  raster_pkg::tri_word_u rec_next;

  // both valids seen and nothing outstanding
  assign accept = !S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en;
  // address and data handshake on the same edge
  assign wr_fire = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;
  // word index from byte address bits 4..2
  assign word_idx = awaddr_q[raster_pkg::addr_width-1:2];

  ////////////////////
  // ready pulse and open-transaction flag
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_AWREADY <= 1'b0;
      S_AXI_WREADY <= 1'b0;
      aw_en <= 1'b1;
    end else if (accept) begin
      S_AXI_AWREADY <= 1'b1;
      S_AXI_WREADY <= 1'b1;
      aw_en <= 1'b0;
    end else begin
      S_AXI_AWREADY <= 1'b0;
      S_AXI_WREADY <= 1'b0;
      // reopen only once the response is taken
      if (S_AXI_BREADY && S_AXI_BVALID) begin
        aw_en <= 1'b1;
      end
    end
  end

  // address held for the handshake edge
  always_ff @(posedge S_AXI_ACLK) begin
    if (accept) begin
      awaddr_q <= S_AXI_AWADDR;
    end
  end

  // word register file, indexes 6 and 7 dropped
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_fire && word_idx <= raster_pkg::last_word_idx) begin
      word_regs.words[word_idx] <= S_AXI_WDATA;
    end
  end

  ////////////////////
  // write response
  ////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_BVALID <= 1'b0;
      S_AXI_BRESP <= 2'b00;
    end else if (wr_fire && !S_AXI_BVALID) begin
      // always okay
      S_AXI_BVALID <= 1'b1;
      S_AXI_BRESP <= 2'b00;
    end else if (S_AXI_BREADY && S_AXI_BVALID) begin
      S_AXI_BVALID <= 1'b0;
    end
  end

  // stored words with the incoming last word on top
  always_comb begin
    rec_next = word_regs;
    rec_next.words[raster_pkg::last_word_idx] = S_AXI_WDATA;
  end

  // push one cycle after the ready pulse; a full queue drops the record
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      push <= 1'b0;
    end else begin
      push <= wr_fire && (word_idx == raster_pkg::last_word_idx) && !fifo_full;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_fire && word_idx == raster_pkg::last_word_idx) begin
      rec <= rec_next;
    end
  end

endmodule

`default_nettype wire

// File: logic/raster_pkg.sv
// shared constants, types and the triangle record layout for the raster design; compile it first
`default_nettype none

package raster_pkg;

  ////////////////////
  // bus and screen constants
  ////////////////////

  // axi4-lite write channel
  localparam int data_width = 32;
  localparam int addr_width = 5;

  // one triangle record is six bus words
  localparam int words_per_tri = 6;
  // writing this word index completes a record
  localparam logic [2:0] last_word_idx = 3'd5;

  // frame buffer is a quarter of the 640x480 scan
  localparam int screen_w = 320;
  localparam int screen_h = 240;
  localparam int fb_depth = screen_w * screen_h;
  localparam int fb_addr_width = 17;

  // triangle queue entries
  localparam int fifo_depth = 16;

  ////////////////////
  // basic types
  ////////////////////

  typedef logic [data_width-1:0] word_t;
  typedef logic [fb_addr_width-1:0] fb_addr_t;
  // rgb332: red 7..5, green 4..2, blue 1..0
  typedef logic [7:0] pixel_t;
  typedef logic [8:0] coord_x_t;
  typedef logic [7:0] coord_y_t;

  // black, written by the clear sweep
  localparam pixel_t clear_color = 8'h00;

  ////////////////////
  // triangle record, word 5 on top and word 0 at the bottom
  ////////////////////

  typedef struct packed {
    // word 5
    logic [31:0] rsvd_inv_area;
    // word 4
    logic [7:0]  pad4;
    pixel_t      color;
    logic [15:0] rsvd_z3;
    // word 3
    logic [7:0]  pad3_hi;
    coord_y_t    v3y;
    logic [6:0]  pad3_lo;
    coord_x_t    v3x;
    // word 2
    logic [15:0] rsvd_z2;
    logic [7:0]  pad2;
    coord_y_t    v2y;
    // word 1
    logic [6:0]  pad1;
    coord_x_t    v2x;
    logic [15:0] rsvd_z1;
    // word 0
    logic [7:0]  pad0_hi;
    coord_y_t    v1y;
    logic [6:0]  pad0_lo;
    coord_x_t    v1x;
  } tri_fields_t;

  // bus side sees raw words, draw side sees the fields
  typedef union packed {
    word_t [words_per_tri-1:0] words;
    tri_fields_t               fields;
  } tri_word_u;

  // one frame buffer write
  typedef struct packed {
    logic     en;
    fb_addr_t addr;
    pixel_t   data;
  } fb_wr_t;

  typedef enum logic [1:0] {
    clear,
    wait_tri,
    fill
  } draw_state_e;

  // linear pixel address, row major
  function automatic fb_addr_t pixel_addr(coord_x_t x, coord_y_t y);
    return fb_addr_t'(y) * fb_addr_t'(screen_w) + fb_addr_t'(x);
  endfunction

endpackage

`default_nettype wire
